//--- source/gfx_pkg.sv
// graphics package
// widths, colour types, opcode and state enums, fixed 16-colour palette

package gfx_pkg;

    localparam int CORDW = 16;  // signed coordinate width
    localparam int CIDXW = 4;   // colour index width
    localparam int CHANW = 4;   // bits per colour channel

    // 12-bit colour, red in top nibble then green then blue
    typedef logic [3*CHANW-1:0] colr_t;

    typedef logic [CIDXW-1:0] cidx_t;          // palette index
    typedef logic signed [CORDW-1:0] coord_t;  // screen coordinate, may be negative

    // command opcodes
    typedef enum logic {
        OP_CLEAR = 1'b0,  // fill framebuffer with one index
        OP_LINE  = 1'b1   // draw line (x0,y0) to (x1,y1)
    } gfx_op_e;

    // renderer FSM
    typedef enum logic [1:0] {
        RS_IDLE  = 2'd0,  // waiting for a command
        RS_CLEAR = 2'd1,  // raster walk over the frame
        RS_LINE  = 2'd2,  // error-term stepping
        RS_LAST  = 2'd3   // final pixel on the output
    } render_state_e;

    // fixed palette, entry 0 is the darkest
    localparam colr_t PALETTE [16] = '{
        12'h112,  // near black
        12'h526,  // plum
        12'hB45,  // red
        12'hE85,  // orange
        12'hFD7,  // yellow
        12'hAE7,  // light green
        12'h3B6,  // green
        12'h277,  // teal
        12'h236,  // navy
        12'h36C,  // blue
        12'h4AF,  // sky
        12'h7EF,  // cyan
        12'hFFF,  // white
        12'h9BC,  // light grey
        12'h578,  // grey
        12'h334   // dark grey
    };

endpackage

//--- source/line_render.sv
// line renderer
// takes clear and line commands, emits one candidate pixel per cycle

`timescale 1ns/1ps

module line_render import gfx_pkg::*; #(
    parameter int fb_width  = 32,
    parameter int fb_height = 16
) (
    input  logic    clk_sys,
    input  logic    rst_sys,
    input  logic    cmd_strobe,  // single-cycle command strobe
    input  gfx_op_e cmd_op,
    input  coord_t  cmd_x0,
    input  coord_t  cmd_y0,
    input  coord_t  cmd_x1,
    input  coord_t  cmd_y1,
    input  cidx_t   cmd_cidx,
    output logic    busy,
    output logic    pt_valid,
    output coord_t  pt_x,
    output coord_t  pt_y,
    output cidx_t   pt_cidx,
    output logic    pt_last
);

    localparam int fb_pixels = fb_width * fb_height;
    localparam int errw = CORDW + 2;  // room for 2*err without overflow

    render_state_e state;
    logic accept;

    coord_t xe, ye;                   // line end point
    logic signed [errw-1:0] dx, dy;   // dx = |x1-x0|, dy = -|y1-y0|
    logic signed [errw-1:0] err;      // error term
    logic x_neg, y_neg;               // step direction

    // command setup
    logic signed [errw-1:0] d_x, d_y;
    logic signed [errw-1:0] adx, ady;

    // next point
    logic signed [errw:0] e2;
    logic mov_x, mov_y;
    coord_t nx, ny;
    logic signed [errw-1:0] nerr;
    logic n_end;  // next point is the final one

    assign accept = cmd_strobe && state == RS_IDLE;  // strobes while busy dropped

    always_comb begin
        d_x = errw'(cmd_x1) - errw'(cmd_x0);
        d_y = errw'(cmd_y1) - errw'(cmd_y0);
        adx = (d_x < 0) ? -d_x : d_x;
        ady = (d_y < 0) ? -d_y : d_y;
    end

    always_comb begin
        e2    = (errw+1)'(err) <<< 1;
        mov_x = e2 >= dy;
        mov_y = e2 <= dx;
        nx    = pt_x;
        ny    = pt_y;
        nerr  = err;
        n_end = 1'b0;
        case (state)
            RS_CLEAR: begin
                if (pt_x == fb_width - 1) begin  // wrap to next row
                    nx = '0;
                    ny = pt_y + 1;
                end else begin
                    nx = pt_x + 1;
                end
                n_end = nx == fb_width - 1 && ny == fb_height - 1;
            end
            RS_LINE: begin
                if (mov_x) nx = x_neg ? pt_x - 1 : pt_x + 1;
                if (mov_y) ny = y_neg ? pt_y - 1 : pt_y + 1;
                nerr  = err + (mov_x ? dy : 0) + (mov_y ? dx : 0);
                n_end = nx == xe && ny == ye;
            end
            default: ;
        endcase
    end

    // control FSM
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= RS_IDLE;
        end else begin
            case (state)
                RS_IDLE: begin
                    if (accept) begin
                        if (cmd_op == OP_CLEAR) begin
                            state <= (fb_pixels == 1) ? RS_LAST : RS_CLEAR;
                        end else begin  // single-point line goes straight to last
                            state <= (cmd_x0 == cmd_x1 && cmd_y0 == cmd_y1) ? RS_LAST : RS_LINE;
                        end
                    end
                end
                RS_CLEAR, RS_LINE: if (n_end) state <= RS_LAST;
                RS_LAST: state <= RS_IDLE;
                default: state <= RS_IDLE;
            endcase
        end
    end

    // point and line registers
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            pt_cidx <= cmd_cidx;
            xe      <= cmd_x1;
            ye      <= cmd_y1;
            dx      <= adx;
            dy      <= -ady;
            err     <= adx - ady;
            x_neg   <= cmd_x1 < cmd_x0;
            y_neg   <= cmd_y1 < cmd_y0;
            if (cmd_op == OP_CLEAR) begin  // clear starts top left
                pt_x <= '0;
                pt_y <= '0;
            end else begin
                pt_x <= cmd_x0;
                pt_y <= cmd_y0;
            end
        end else if (state == RS_CLEAR || state == RS_LINE) begin
            pt_x <= nx;
            pt_y <= ny;
            err  <= nerr;
        end
    end

    assign pt_valid = state != RS_IDLE;
    assign pt_last  = state == RS_LAST;
    assign busy     = state != RS_IDLE;

    // pixels only start after an accepted command
    assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(pt_valid) |-> $past(state == RS_IDLE && cmd_strobe));

    // final pixel is valid and ends the run
    assert property (@(posedge clk_sys) disable iff (rst_sys)
        pt_last |-> pt_valid ##1 !busy);

endmodule

//--- source/pixel_addr.sv
// pixel address stage
// clips points to the frame and forms y*fb_width+x in two cycles

`timescale 1ns/1ps

module pixel_addr import gfx_pkg::*; #(
    parameter int fb_width  = 32,
    parameter int fb_height = 16,
    localparam int addr_w   = $clog2(fb_width * fb_height)
) (
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              pt_valid,
    input  coord_t            pt_x,
    input  coord_t            pt_y,
    input  cidx_t             pt_cidx,
    input  logic              pt_last,
    output logic              wr_en,
    output logic [addr_w-1:0] wr_addr,
    output cidx_t             wr_cidx,
    output logic              draw_done  // strobe with the last write
);

    localparam int fb_pixels = fb_width * fb_height;

    logic s1_valid, s1_in, s1_last;
    logic [addr_w-1:0] s1_row, s1_x;  // row base and column
    cidx_t s1_cidx;

    // stage 1 does the bounds test and the row product
    always_ff @(posedge clk_sys) begin
        s1_in   <= pt_x >= 0 && pt_x < fb_width && pt_y >= 0 && pt_y < fb_height;
        s1_row  <= addr_w'(pt_y) * addr_w'(fb_width);  // only meaningful when inside
        s1_x    <= addr_w'(pt_x);
        s1_cidx <= pt_cidx;
        if (rst_sys) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= pt_valid;
            s1_last  <= pt_valid && pt_last;
        end
    end

    // stage 2 forms the linear address and writes only inside the frame
    always_ff @(posedge clk_sys) begin
        wr_addr <= s1_row + s1_x;
        wr_cidx <= s1_cidx;
        if (rst_sys) begin
            wr_en     <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            wr_en     <= s1_valid && s1_in;
            draw_done <= s1_last;  // clipped last pixel still finishes
        end
    end

    assert property (@(posedge clk_sys) disable iff (rst_sys)
        wr_en |-> wr_addr < fb_pixels);

endmodule

//--- source/frame_ram.sv
// frame memory
// colour index per pixel, one write port and one registered read port

`timescale 1ns/1ps

module frame_ram import gfx_pkg::*; #(
    parameter int fb_width  = 32,
    parameter int fb_height = 16,
    localparam int addr_w   = $clog2(fb_width * fb_height)
) (
    input  logic              clk_sys,
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  cidx_t             wr_cidx,
    input  logic [addr_w-1:0] rd_addr,
    output cidx_t             rd_cidx  // one cycle after rd_addr
);

    localparam int fb_pixels = fb_width * fb_height;

    cidx_t mem [fb_pixels];  // undefined until cleared

    // write port
    always_ff @(posedge clk_sys) begin
        if (wr_en) mem[wr_addr] <= wr_cidx;
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk_sys) begin
        rd_cidx <= mem[rd_addr];
    end

endmodule

//--- source/scan_out.sv
// scan-out engine
// raster read of the framebuffer on request with palette lookup to 12-bit colour

`timescale 1ns/1ps

module scan_out import gfx_pkg::*; #(
    parameter int fb_width  = 32,
    parameter int fb_height = 16,
    localparam int addr_w   = $clog2(fb_width * fb_height)
) (
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              scan_strobe,
    output logic              scan_busy,
    output logic              scan_done,  // with the last pixel
    output logic [addr_w-1:0] rd_addr,
    input  cidx_t             rd_cidx,
    output logic              pix_valid,
    output colr_t             pix_colr
);

    localparam int fb_pixels = fb_width * fb_height;

    logic rd_act;          // address phase running
    logic rd_end;          // final address this cycle
    logic v1, l1;          // valid and last aligned with rd_cidx

    assign rd_end = rd_act && rd_addr == addr_w'(fb_pixels - 1);

    // address counter runs x fastest since the address is linear
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            rd_act  <= 1'b0;
            rd_addr <= '0;
        end else if (scan_strobe && !scan_busy) begin
            rd_act  <= 1'b1;
            rd_addr <= '0;
        end else if (rd_act) begin
            rd_act  <= !rd_end;
            rd_addr <= rd_end ? '0 : rd_addr + 1'b1;
        end
    end

    // valid and last delayed through memory read and palette register
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            v1        <= 1'b0;
            l1        <= 1'b0;
            pix_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            v1        <= rd_act;
            l1        <= rd_end;
            pix_valid <= v1;
            scan_done <= l1;
        end
    end

    always_ff @(posedge clk_sys) begin
        pix_colr <= PALETTE[rd_cidx];  // index to colour
    end

    // busy from acceptance until the last pixel has gone out
    always_ff @(posedge clk_sys) begin
        if (rst_sys) scan_busy <= 1'b0;
        else if (scan_strobe && !scan_busy) scan_busy <= 1'b1;
        else if (scan_done) scan_busy <= 1'b0;
    end

    assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(pix_valid) |-> scan_busy || $past(scan_busy));

endmodule

//--- source/gfx_top.sv
// pixel drawing subsystem
// renderer and address stage feed the frame memory, scan-out reads it back

`timescale 1ns/1ps

module gfx_top import gfx_pkg::*; #(
    parameter int fb_width  = 32,  // framebuffer width in pixels
    parameter int fb_height = 16   // framebuffer height in pixels
) (
    input  logic    clk_sys,
    input  logic    rst_sys,
    input  logic    cmd_strobe,
    input  gfx_op_e cmd_op,
    input  coord_t  cmd_x0,
    input  coord_t  cmd_y0,
    input  coord_t  cmd_x1,
    input  coord_t  cmd_y1,
    input  cidx_t   cmd_cidx,
    output logic    busy,
    output logic    draw_done,
    input  logic    scan_strobe,
    output logic    pix_valid,
    output colr_t   pix_colr,
    output logic    scan_busy,
    output logic    scan_done
);

    localparam int addr_w = $clog2(fb_width * fb_height);

    // renderer to address stage
    logic   pt_valid, pt_last;
    coord_t pt_x, pt_y;
    cidx_t  pt_cidx;

    // framebuffer ports
    logic              wr_en;
    logic [addr_w-1:0] wr_addr, rd_addr;
    cidx_t             wr_cidx, rd_cidx;

    line_render #(.fb_width(fb_width), .fb_height(fb_height)) line_render_inst (
        .clk_sys,
        .rst_sys,
        .cmd_strobe,
        .cmd_op,
        .cmd_x0,
        .cmd_y0,
        .cmd_x1,
        .cmd_y1,
        .cmd_cidx,
        .busy,
        .pt_valid,
        .pt_x,
        .pt_y,
        .pt_cidx,
        .pt_last
    );

    pixel_addr #(.fb_width(fb_width), .fb_height(fb_height)) pixel_addr_inst (
        .clk_sys,
        .rst_sys,
        .pt_valid,
        .pt_x,
        .pt_y,
        .pt_cidx,
        .pt_last,
        .wr_en,
        .wr_addr,
        .wr_cidx,
        .draw_done
    );

    frame_ram #(.fb_width(fb_width), .fb_height(fb_height)) frame_ram_inst (
        .clk_sys,
        .wr_en,
        .wr_addr,
        .wr_cidx,
        .rd_addr,
        .rd_cidx
    );

    scan_out #(.fb_width(fb_width), .fb_height(fb_height)) scan_out_inst (
        .clk_sys,
        .rst_sys,
        .scan_strobe,
        .scan_busy,
        .scan_done,
        .rd_addr,
        .rd_cidx,
        .pix_valid,
        .pix_colr
    );

endmodule

//--- tests/tb_clock.sv
// testbench clock source
// free-running clk_sys, 4 ns period

`timescale 1ns/1ps

module tb_clock #(
    parameter real period_ns = 4.0
) (
    output logic clk_sys
);

    initial begin
        clk_sys = 1'b0;  // first rising edge after half a period
        forever #(period_ns / 2.0) clk_sys = ~clk_sys;
    end

endmodule

//--- tests/gfx_tb.sv
// testbench for the pixel drawing subsystem
// shadow framebuffer model, LFSR stimulus, scan comparison and watchdog

`timescale 1ns/1ps

module gfx_tb import gfx_pkg::*;;

    localparam int fb_width  = 32;  // DUT default size
    localparam int fb_height = 16;
    localparam int fb_pixels = fb_width * fb_height;
    localparam int n_cmd_total  = 74;  // every strobe, ignored ones too
    localparam int n_scan_total = 7;
    localparam int timeout_cycles = (n_cmd_total + n_scan_total) * (fb_pixels + 4) + 200;
    localparam int wait_max = fb_pixels + 8;  // per draw or scan

    logic    clk_sys;
    logic    rst_sys;
    logic    cmd_strobe, scan_strobe;
    gfx_op_e cmd_op;
    coord_t  cmd_x0, cmd_y0, cmd_x1, cmd_y1;
    cidx_t   cmd_cidx;
    logic    busy, draw_done;
    logic    pix_valid, scan_busy, scan_done;
    colr_t   pix_colr;

    cidx_t shadow [fb_pixels];           // expected framebuffer contents
    logic [15:0] lfsr_state = 16'd18479;
    int    pix_pos = 0;                  // raster position in current scan
    int    errors = 0, n_checks = 0, n_tests = 0, test_err0 = 0;
    int    cycle_count = 0;
    string cur_test = "none";

    // octant end points relative to the centre
    int oct_dx [8] = '{12, 5, -5, -12, -12, -5, 5, 12};
    int oct_dy [8] = '{5, 7, 7, 5, -5, -7, -7, -5};

    tb_clock clock_gen (.clk_sys(clk_sys));

    gfx_top uut (
        .clk_sys, .rst_sys,
        .cmd_strobe, .cmd_op, .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_cidx,
        .busy, .draw_done,
        .scan_strobe, .pix_valid, .pix_colr, .scan_busy, .scan_done
    );

    // 16-bit Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // reference model, draws one command into the shadow framebuffer
    function automatic void draw_model(input gfx_op_e op, input int x0, input int y0,
                                       input int x1, input int y1, input cidx_t c);
        int x, y, sx, sy, ddx, ddy, err, e2, k;
        bit fin;
        if (op == OP_CLEAR) begin
            for (k = 0; k < fb_pixels; k++) shadow[k] = c;
            return;
        end
        ddx = (x1 > x0) ? x1 - x0 : x0 - x1;
        ddy = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
        sx  = (x1 < x0) ? -1 : 1;
        sy  = (y1 < y0) ? -1 : 1;
        err = ddx + ddy;
        x   = x0;
        y   = y0;
        fin = 1'b0;
        while (!fin) begin
            if (x >= 0 && x < fb_width && y >= 0 && y < fb_height)
                shadow[y * fb_width + x] = c;  // clipped points skipped
            if (x == x1 && y == y1) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= ddy) begin
                    err += ddy;
                    x   += sx;
                end
                if (e2 <= ddx) begin
                    err += ddx;
                    y   += sy;
                end
            end
        end
    endfunction

    task automatic check_colr(input string what, input colr_t exp, input colr_t act);
        n_checks++;
        if (exp !== act) begin
            $display("** Error %s: %s expected %03h actual %03h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        n_checks++;
        if (exp !== act) begin
            $display("** Error %s: %s expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        n_checks++;
        if (exp != act) begin
            $display("** Error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // drive point, 1 ns after the rising edge
    task automatic tick;
        @(posedge clk_sys);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test;
        n_tests++;
        if (errors == test_err0) $display("test %s: passed", cur_test);
        else $display("test %s: failed with %0d errors", cur_test, errors - test_err0);
    endtask

    // issue a command as soon as busy is low, model follows
    task automatic send_cmd(input gfx_op_e op, input int x0, input int y0,
                            input int x1, input int y1, input int c);
        while (busy) tick;
        cmd_op     = op;
        cmd_x0     = coord_t'(x0);
        cmd_y0     = coord_t'(y0);
        cmd_x1     = coord_t'(x1);
        cmd_y1     = coord_t'(y1);
        cmd_cidx   = cidx_t'(c);
        cmd_strobe = 1'b1;
        tick;
        cmd_strobe = 1'b0;
        check_flag("busy after accept", 1'b1, busy);
        draw_model(op, x0, y0, x1, y1, cidx_t'(c));
    endtask

    // busy low first, so an older draw_done is not mistaken for this one
    task automatic finish_draw;
        int n;
        n = 0;
        while (busy && n < wait_max) begin
            tick;
            n++;
        end
        while (!draw_done && n < wait_max) begin
            tick;
            n++;
        end
        if (!draw_done) begin
            $display("test %s: draw_done did not arrive after the command", cur_test);
            errors++;
        end
    endtask

    // full scan, comparator process checks the pixels
    task automatic do_scan(input bit extra_strobe);
        int n;
        while (scan_busy) tick;
        pix_pos     = 0;
        scan_strobe = 1'b1;
        tick;
        scan_strobe = 1'b0;
        check_flag("scan_busy after accept", 1'b1, scan_busy);
        n = 0;
        while (!scan_done && n < wait_max) begin
            tick;
            n++;
            scan_strobe = extra_strobe && n == 40;  // dropped, scan still running
            if (scan_strobe) check_flag("scan_busy at second strobe", 1'b1, scan_busy);
        end
        scan_strobe = 1'b0;
        if (!scan_done) begin
            $display("test %s: scan_done did not arrive during the scan", cur_test);
            errors++;
        end
        repeat (8) tick;  // catch any stray pixels
        check_count("valid pixel count", fb_pixels, pix_pos);
        check_flag("scan_busy after scan", 1'b0, scan_busy);
    endtask

    // comparator, outputs are stable at the falling edge
    always @(negedge clk_sys) begin
        if (pix_valid) begin
            if (pix_pos < fb_pixels) begin
                check_colr("pixel colour", PALETTE[shadow[pix_pos]], pix_colr);
                check_flag("scan_done on last pixel", pix_pos == fb_pixels - 1, scan_done);
            end else begin
                $display("test %s: pix_valid high after the frame was complete", cur_test);
                errors++;
            end
            pix_pos++;
        end else if (scan_done) begin
            $display("test %s: scan_done high without pix_valid", cur_test);
            errors++;
        end
    end

    // watchdog
    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int i, rx0, ry0, rx1, ry1, rc;
        rst_sys     = 1'b1;
        cmd_strobe  = 1'b0;
        cmd_op      = OP_CLEAR;
        cmd_x0      = '0;
        cmd_y0      = '0;
        cmd_x1      = '0;
        cmd_y1      = '0;
        cmd_cidx    = '0;
        scan_strobe = 1'b0;
        repeat (16) @(posedge clk_sys);
        #1 rst_sys = 1'b0;

        begin_test("reset");
        check_flag("busy", 1'b0, busy);
        check_flag("draw_done", 1'b0, draw_done);
        check_flag("pix_valid", 1'b0, pix_valid);
        check_flag("scan_busy", 1'b0, scan_busy);
        check_flag("scan_done", 1'b0, scan_done);
        end_test();

        begin_test("clear");
        send_cmd(OP_CLEAR, 0, 0, 0, 0, 9);
        finish_draw();
        do_scan(1'b0);
        end_test();

        begin_test("lines");
        send_cmd(OP_CLEAR, 0, 0, 0, 0, 0);
        finish_draw();
        send_cmd(OP_LINE, 2, 1, 29, 1, 4);    // horizontal
        finish_draw();
        send_cmd(OP_LINE, 30, 0, 30, 15, 6);  // vertical
        finish_draw();
        send_cmd(OP_LINE, 0, 0, 15, 15, 12);  // diagonal
        finish_draw();
        do_scan(1'b0);
        send_cmd(OP_CLEAR, 0, 0, 0, 0, 0);
        finish_draw();
        for (i = 0; i < 8; i++) begin  // centre outwards
            send_cmd(OP_LINE, 16, 8, 16 + oct_dx[i], 8 + oct_dy[i], i + 1);
            finish_draw();
        end
        do_scan(1'b0);
        send_cmd(OP_CLEAR, 0, 0, 0, 0, 0);
        finish_draw();
        for (i = 0; i < 8; i++) begin  // same lines reversed
            send_cmd(OP_LINE, 16 + oct_dx[i], 8 + oct_dy[i], 16, 8, i + 8);
            finish_draw();
        end
        do_scan(1'b0);
        end_test();

        begin_test("clipped");
        send_cmd(OP_CLEAR, 0, 0, 0, 0, 2);
        finish_draw();
        send_cmd(OP_LINE, -5, -3, 40, 20, 10);
        finish_draw();
        send_cmd(OP_LINE, -10, 8, -2, 12, 11);  // fully left of the frame
        finish_draw();
        send_cmd(OP_LINE, 31, 15, 45, -6, 12);
        finish_draw();
        send_cmd(OP_LINE, 10, -4, 10, 20, 13);
        finish_draw();
        send_cmd(OP_LINE, -3, 15, 34, 15, 14);
        finish_draw();
        send_cmd(OP_LINE, 5, 16, 25, 30, 15);   // fully below
        finish_draw();
        do_scan(1'b0);
        end_test();

        begin_test("random");
        send_cmd(OP_CLEAR, 0, 0, 0, 0, 1);
        finish_draw();
        for (i = 0; i < 40; i++) begin
            take_bits(6, rx0);
            take_bits(5, ry0);
            take_bits(6, rx1);
            take_bits(5, ry1);
            take_bits(4, rc);
            send_cmd(OP_LINE, rx0 % 40 - 4, ry0 % 24 - 4, rx1 % 40 - 4, ry1 % 24 - 4, rc);
        end
        finish_draw();
        do_scan(1'b0);
        end_test();

        begin_test("ignored strobes");
        send_cmd(OP_CLEAR, 0, 0, 0, 0, 3);
        finish_draw();
        send_cmd(OP_LINE, 0, 2, 31, 13, 12);
        tick;
        tick;
        check_flag("busy at second strobe", 1'b1, busy);
        cmd_op     = OP_CLEAR;  // never reaches the model
        cmd_cidx   = 4'd7;
        cmd_strobe = 1'b1;
        tick;
        cmd_strobe = 1'b0;
        finish_draw();
        do_scan(1'b1);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- src.f
source/gfx_pkg.sv
source/line_render.sv
source/pixel_addr.sv
source/frame_ram.sv
source/scan_out.sv
source/gfx_top.sv
tests/tb_clock.sv
tests/gfx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the gfx testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module gfx_tb -f src.f -o gfx_sim
./obj_dir/gfx_sim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
